/* rv32v_types_pkg.sv */
/*
 * Vector-side definitions for the memory stage.
 * Element widths above 32 bits are not supported.
 * One vector register is four banks of one word each.
 */

package rv32v_types_pkg;

    // Default lane count, passed down from the top level
    localparam int num_lanes_c = 4;

    // Bytes held by one vector register
    localparam int vreg_bytes_c = 16;

    // Element width encoding
    typedef enum logic [1:0] {
        eew_8  = 2'd0,
        eew_16 = 2'd1,
        eew_32 = 2'd2
    } eew_t;

    // Byte count of one element
    function automatic logic [2:0] eew_bytes(eew_t eew);
        case (eew)
            eew_8:   return 3'd1;
            eew_16:  return 3'd2;
            default: return 3'd4;
        endcase
    endfunction

endpackage

/* mem_bus_pkg.sv */
/*
 * Memory-side definitions: bus widths, scalar load types and operation kinds.
 * Load type codes follow the RV32 funct3 encoding.
 */

package mem_bus_pkg;

    localparam int addr_width_c = 32;
    localparam int word_width_c = 32;

    typedef logic [word_width_c-1:0] word_t;

    // Scalar load type, also gives the store width
    typedef enum logic [2:0] {
        lb  = 3'b000,
        lh  = 3'b001,
        lw  = 3'b010,
        lbu = 3'b100,
        lhu = 3'b101
    } load_type_t;

    typedef enum logic [1:0] {
        acc_sload  = 2'd0,
        acc_sstore = 2'd1,
        acc_vload  = 2'd2,
        acc_vstore = 2'd3
    } access_kind_t;

endpackage

/* vmem_serializer.sv */
/*
 * Splits a vector access into one access per active lane.
 * Lane j of micro-op u goes to base + (u * NUM_LANES + j) * stride.
 * Misaligned elements that cross a word boundary are not handled.
 */
`timescale 1ns/100ps

module vmem_serializer #(
    parameter int NUM_LANES = 4
) (
    input  logic                                CLK,
    input  logic                                rst,
    input  logic                                vstart,
    input  logic                                lane_done,
    input  mem_bus_pkg::word_t                  base,
    input  mem_bus_pkg::word_t                  stride,
    input  rv32v_types_pkg::eew_t               eew,
    input  logic [1:0]                          uop_num,
    input  logic [NUM_LANES-1:0]                lane_mask,
    input  mem_bus_pkg::word_t [NUM_LANES-1:0]  vs2_data,
    output logic [$clog2(NUM_LANES)-1:0]        lane_idx,
    output logic                                lane_active,
    output mem_bus_pkg::word_t                  lane_addr,
    output mem_bus_pkg::word_t                  lane_wdata,
    output logic [3:0]                          lane_strb,
    output logic                                last_lane
);

    localparam int IDX_W = $clog2(NUM_LANES);

    logic [IDX_W-1:0]       first_idx;
    logic [IDX_W-1:0]       next_idx;
    logic                   more_above;
    logic [3:0]             size_strb;
    mem_bus_pkg::word_t     elem_num;
    mem_bus_pkg::word_t     elem_word;

    // Lowest set bit overall and lowest set bit above the current lane
    always_comb begin
        first_idx  = '0;
        next_idx   = lane_idx;
        more_above = 1'b0;
        for (int j = NUM_LANES - 1; j >= 0; j--) begin
            if (lane_mask[j]) begin
                first_idx = IDX_W'(j);
            end
            if (lane_mask[j] && j > lane_idx) begin
                next_idx   = IDX_W'(j);
                more_above = 1'b1;
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (rst) begin
            lane_idx <= '0;
        end else if (vstart) begin
            lane_idx <= first_idx;
        end else if (lane_done && more_above) begin
            lane_idx <= next_idx;
        end
    end

    assign lane_active = lane_mask[lane_idx];
    assign last_lane   = !more_above;

    assign elem_num  = mem_bus_pkg::word_t'(uop_num) * NUM_LANES + lane_idx;
    assign lane_addr = base + elem_num * stride;

    always_comb begin
        case (eew)
            rv32v_types_pkg::eew_8:  elem_word = {24'b0, vs2_data[lane_idx][7:0]};
            rv32v_types_pkg::eew_16: elem_word = {16'b0, vs2_data[lane_idx][15:0]};
            default:                 elem_word = vs2_data[lane_idx];
        endcase
    end

    assign size_strb  = 4'((5'd1 << rv32v_types_pkg::eew_bytes(eew)) - 5'd1);
    assign lane_wdata = elem_word << {lane_addr[1:0], 3'b000};
    assign lane_strb  = size_strb << lane_addr[1:0];

    // Each step stays in range and lands on a lane the mask enables
    a_lane_range: assert property (@(posedge CLK) disable iff (rst)
        lane_done && more_above |=> lane_active && lane_idx < NUM_LANES);

endmodule

/* load_store_ctrl.sv */
/*
 * APB requester with load extraction and extension.
 * Request fields are captured in the cycle req is high.
 * paddr is word aligned; byte lanes are chosen by pstrb.
 * pslverr is not handled here.
 */
`timescale 1ns/100ps

module load_store_ctrl (
    input  logic                                   CLK,
    input  logic                                   rst,
    input  logic                                   req,
    input  logic [mem_bus_pkg::addr_width_c-1:0]   addr,
    input  mem_bus_pkg::word_t                     wdata,
    input  logic [3:0]                             strb,
    input  logic                                   write,
    input  rv32v_types_pkg::eew_t                  size,
    input  logic                                   signed_ld,
    output logic                                   done,
    output mem_bus_pkg::word_t                     load_data,
    output logic [mem_bus_pkg::addr_width_c-1:0]   paddr,
    output logic                                   psel,
    output logic                                   penable,
    output logic                                   pwrite,
    output mem_bus_pkg::word_t                     pwdata,
    output logic [3:0]                             pstrb,
    input  mem_bus_pkg::word_t                     prdata,
    input  logic                                   pready
);

    typedef enum logic [1:0] {lsc_idle, lsc_setup, lsc_access} lsc_state_t;

    lsc_state_t                             state;
    logic [mem_bus_pkg::addr_width_c-1:0]   addr_q;
    mem_bus_pkg::word_t                     wdata_q;
    mem_bus_pkg::word_t                     rd_shift;
    logic [3:0]                             strb_q;
    logic                                   write_q;
    logic                                   signed_q;
    rv32v_types_pkg::eew_t                  size_q;

    always_ff @(posedge CLK) begin
        if (rst) begin
            state <= lsc_idle;
        end else begin
            case (state)
                lsc_idle:   state <= req ? lsc_setup : lsc_idle;
                lsc_setup:  state <= lsc_access;
                default:    state <= pready ? lsc_idle : lsc_access;
            endcase
        end
    end

    // Request capture
    always_ff @(posedge CLK) begin
        if (state == lsc_idle && req) begin
            addr_q   <= addr;
            wdata_q  <= wdata;
            strb_q   <= strb;
            write_q  <= write;
            size_q   <= size;
            signed_q <= signed_ld;
        end
    end

    assign psel    = (state != lsc_idle);
    assign penable = (state == lsc_access);
    assign paddr   = {addr_q[mem_bus_pkg::addr_width_c-1:2], 2'b00};
    assign pwrite  = write_q;
    assign pwdata  = wdata_q;
    assign pstrb   = write_q ? strb_q : 4'b0000;
    assign done    = penable && pready;

    // Addressed element moved down to bit 0
    assign rd_shift = prdata >> {addr_q[1:0], 3'b000};

    always_comb begin
        case (size_q)
            rv32v_types_pkg::eew_8:
                load_data = {{24{signed_q & rd_shift[7]}}, rd_shift[7:0]};
            rv32v_types_pkg::eew_16:
                load_data = {{16{signed_q & rd_shift[15]}}, rd_shift[15:0]};
            default:
                load_data = rd_shift;
        endcase
    end

    a_penable_psel: assert property (@(posedge CLK) disable iff (rst)
        penable |-> psel);

    // Transfer holds its address until the memory accepts it
    a_paddr_stable: assert property (@(posedge CLK) disable iff (rst)
        psel && !(penable && pready) |=> psel && $stable(paddr));

endmodule

/* vwrite_xbar.sv */
/*
 * Write crossbar for one vector register bank.
 * Element index is uop_num * NUM_LANES + lane_idx.
 * Elements placed past the end of the register are dropped.
 */
`timescale 1ns/100ps

module vwrite_xbar #(
    parameter int NUM_LANES = 4,
    parameter int BANK      = 0
) (
    input  logic [$clog2(NUM_LANES)-1:0]  lane_idx,
    input  logic                          lane_wen,
    input  mem_bus_pkg::word_t            load_data,
    input  rv32v_types_pkg::eew_t         eew,
    input  logic [1:0]                    uop_num,
    output mem_bus_pkg::word_t            bank_wdata,
    output logic [3:0]                    bank_byte_wen
);

    logic [7:0]     elem_idx;
    logic [7:0]     byte_pos;
    logic [3:0]     size_strb;
    logic           in_bank;

    assign elem_idx = 8'(uop_num) * 8'(NUM_LANES) + 8'(lane_idx);
    assign byte_pos = elem_idx * 8'(rv32v_types_pkg::eew_bytes(eew));
    assign in_bank  = (byte_pos < 8'(rv32v_types_pkg::vreg_bytes_c))
                   && (byte_pos[7:2] == 6'(BANK));

    // Element copied to every slot of the bank word
    always_comb begin
        case (eew)
            rv32v_types_pkg::eew_8:  bank_wdata = {4{load_data[7:0]}};
            rv32v_types_pkg::eew_16: bank_wdata = {2{load_data[15:0]}};
            default:                 bank_wdata = load_data;
        endcase
    end

    assign size_strb     = 4'((5'd1 << rv32v_types_pkg::eew_bytes(eew)) - 5'd1);
    assign bank_byte_wen = (lane_wen && in_bank) ? size_strb << byte_pos[1:0] : 4'b0000;

endmodule

/* mem_stage_ctrl.sv */
/*
 * Sequencer for one memory operation at a time.
 * Scalar operations issue one transfer, vector operations one per active lane.
 * Scalar store width comes from load_type, using the funct3 encoding.
 */
`timescale 1ns/100ps

module mem_stage_ctrl #(
    parameter int NUM_LANES = 4
) (
    input  logic                                   CLK,
    input  logic                                   rst,
    input  logic                                   op_valid,
    input  mem_bus_pkg::access_kind_t              op_kind,
    input  mem_bus_pkg::word_t                     base,
    input  mem_bus_pkg::word_t                     scalar_store_data,
    input  mem_bus_pkg::load_type_t                load_type,
    input  rv32v_types_pkg::eew_t                  eew,
    input  logic                                   lane_active,
    input  mem_bus_pkg::word_t                     lane_addr,
    input  mem_bus_pkg::word_t                     lane_wdata,
    input  logic [3:0]                             lane_strb,
    input  logic                                   last_lane,
    input  logic                                   done,
    input  mem_bus_pkg::word_t                     load_data,
    input  logic                                   pslverr_in,
    output logic                                   stall,
    output logic                                   vstart,
    output logic                                   lane_done,
    output logic                                   req,
    output logic [mem_bus_pkg::addr_width_c-1:0]   addr,
    output mem_bus_pkg::word_t                     wdata,
    output logic [3:0]                             strb,
    output logic                                   write,
    output rv32v_types_pkg::eew_t                  size,
    output logic                                   signed_ld,
    output logic                                   reg_write,
    output mem_bus_pkg::word_t                     reg_wdata,
    output logic                                   lane_wen,
    output logic                                   bus_error
);

    typedef enum logic [1:0] {st_idle, st_issue, st_wait} state_t;

    state_t                             state;
    state_t                             state_n;
    logic                               is_vec;
    logic                               finish;
    logic                               sc_signed;
    logic [3:0]                         sc_strb;
    rv32v_types_pkg::eew_t              sc_size;
    logic [$clog2(NUM_LANES+1)-1:0]     lanes_issued;

    assign is_vec = (op_kind == mem_bus_pkg::acc_vload) || (op_kind == mem_bus_pkg::acc_vstore);
    assign write  = (op_kind == mem_bus_pkg::acc_sstore) || (op_kind == mem_bus_pkg::acc_vstore);

    always_comb begin
        state_n = state;
        vstart  = 1'b0;
        req     = 1'b0;
        finish  = 1'b0;
        case (state)
            st_idle: begin
                if (op_valid) begin
                    vstart  = is_vec;
                    state_n = st_issue;
                end
            end
            st_issue: begin
                // Empty mask leaves no active lane
                if (!is_vec || lane_active) begin
                    req     = 1'b1;
                    state_n = st_wait;
                end else begin
                    finish  = 1'b1;
                    state_n = st_idle;
                end
            end
            default: begin
                if (done) begin
                    if (!is_vec || last_lane) begin
                        finish  = 1'b1;
                        state_n = st_idle;
                    end else begin
                        state_n = st_issue;
                    end
                end
            end
        endcase
    end

    always_ff @(posedge CLK) begin
        if (rst) begin
            state <= st_idle;
        end else begin
            state <= state_n;
        end
    end

    // Transfers issued in the current operation
    always_ff @(posedge CLK) begin
        if (rst || state == st_idle) begin
            lanes_issued <= '0;
        end else if (req) begin
            lanes_issued <= lanes_issued + 1'b1;
        end
    end

    always_comb begin
        case (load_type)
            mem_bus_pkg::lb:  {sc_size, sc_signed} = {rv32v_types_pkg::eew_8, 1'b1};
            mem_bus_pkg::lh:  {sc_size, sc_signed} = {rv32v_types_pkg::eew_16, 1'b1};
            mem_bus_pkg::lbu: {sc_size, sc_signed} = {rv32v_types_pkg::eew_8, 1'b0};
            mem_bus_pkg::lhu: {sc_size, sc_signed} = {rv32v_types_pkg::eew_16, 1'b0};
            default:          {sc_size, sc_signed} = {rv32v_types_pkg::eew_32, 1'b0};
        endcase
    end

    assign sc_strb = 4'((5'd1 << rv32v_types_pkg::eew_bytes(sc_size)) - 5'd1);

    // Scalar stores land at the byte offset of the address
    assign addr      = is_vec ? lane_addr : base;
    assign wdata     = is_vec ? lane_wdata : scalar_store_data << {base[1:0], 3'b000};
    assign strb      = is_vec ? lane_strb : sc_strb << base[1:0];
    assign size      = is_vec ? eew : sc_size;
    assign signed_ld = !is_vec && sc_signed;

    assign stall     = op_valid && !finish;
    assign lane_done = done && is_vec;
    assign lane_wen  = done && (op_kind == mem_bus_pkg::acc_vload);
    assign reg_write = done && (op_kind == mem_bus_pkg::acc_sload);
    assign reg_wdata = load_data;
    assign bus_error = done && pslverr_in;

    // One transfer in flight at a time
    a_req_single: assert property (@(posedge CLK) disable iff (rst)
        req |=> !req until_with done);

    a_lane_count: assert property (@(posedge CLK) disable iff (rst)
        lanes_issued <= NUM_LANES);

endmodule

/* mem_stage.sv */
/*
 * Memory stage of an RV32 pipeline with a vector unit.
 * Operation fields must stay stable while stall is high.
 * One APB requester serves both scalar and vector accesses.
 * Number of register banks equals NUM_LANES.
 */
`timescale 1ns/100ps

module mem_stage #(
    parameter int NUM_LANES = rv32v_types_pkg::num_lanes_c
) (
    input  logic                                   CLK,
    input  logic                                   rst,
    input  logic                                   op_valid,
    input  mem_bus_pkg::access_kind_t              op_kind,
    input  mem_bus_pkg::word_t                     base,
    input  mem_bus_pkg::word_t                     stride,
    input  rv32v_types_pkg::eew_t                  eew,
    input  logic [1:0]                             uop_num,
    input  logic [NUM_LANES-1:0]                   lane_mask,
    input  mem_bus_pkg::word_t                     scalar_store_data,
    input  mem_bus_pkg::load_type_t                load_type,
    input  mem_bus_pkg::word_t [NUM_LANES-1:0]     vs2_data,
    output logic                                   stall,
    output logic                                   reg_write,
    output mem_bus_pkg::word_t                     reg_wdata,
    output mem_bus_pkg::word_t [NUM_LANES-1:0]     vwdata,
    output logic [NUM_LANES-1:0][3:0]              vbyte_wen,
    output logic                                   bus_error,
    output logic [mem_bus_pkg::addr_width_c-1:0]   paddr,
    output logic                                   psel,
    output logic                                   penable,
    output logic                                   pwrite,
    output mem_bus_pkg::word_t                     pwdata,
    output logic [3:0]                             pstrb,
    input  mem_bus_pkg::word_t                     prdata,
    input  logic                                   pready,
    input  logic                                   pslverr
);

    logic [$clog2(NUM_LANES)-1:0]               lane_idx;
    logic                                       lane_active;
    logic                                       last_lane;
    logic                                       vstart;
    logic                                       lane_done;
    logic                                       lane_wen;
    mem_bus_pkg::word_t                         lane_addr;
    mem_bus_pkg::word_t                         lane_wdata;
    logic [3:0]                                 lane_strb;
    logic                                       req;
    logic                                       write;
    logic                                       signed_ld;
    logic                                       done;
    logic [mem_bus_pkg::addr_width_c-1:0]       addr;
    mem_bus_pkg::word_t                         wdata;
    mem_bus_pkg::word_t                         load_data;
    logic [3:0]                                 strb;
    rv32v_types_pkg::eew_t                      size;

    mem_stage_ctrl #(.NUM_LANES(NUM_LANES)) u_ctrl (
        .CLK, .rst, .op_valid, .op_kind, .base, .scalar_store_data, .load_type, .eew,
        .lane_active, .lane_addr, .lane_wdata, .lane_strb, .last_lane,
        .done, .load_data, .pslverr_in(pslverr),
        .stall, .vstart, .lane_done, .req, .addr, .wdata, .strb, .write, .size,
        .signed_ld, .reg_write, .reg_wdata, .lane_wen, .bus_error
    );

    vmem_serializer #(.NUM_LANES(NUM_LANES)) u_serializer (
        .CLK, .rst, .vstart, .lane_done, .base, .stride, .eew, .uop_num, .lane_mask,
        .vs2_data, .lane_idx, .lane_active, .lane_addr, .lane_wdata, .lane_strb, .last_lane
    );

    load_store_ctrl u_lsc (
        .CLK, .rst, .req, .addr, .wdata, .strb, .write, .size, .signed_ld, .done, .load_data,
        .paddr, .psel, .penable, .pwrite, .pwdata, .pstrb, .prdata, .pready
    );

    // One crossbar per register bank
    for (genvar b = 0; b < NUM_LANES; b++) begin : gen_xbar
        vwrite_xbar #(.NUM_LANES(NUM_LANES), .BANK(b)) u_xbar (
            .lane_idx, .lane_wen, .load_data, .eew, .uop_num,
            .bank_wdata(vwdata[b]),
            .bank_byte_wen(vbyte_wen[b])
        );
    end

endmodule

/* tb_mem_stage.sv */
/*
 * Self-checking testbench for mem_stage.
 * Operations and expected results come from mem_stage_stimulus.txt.
 * APB memory covers 1 KiB; addresses at or above err_limit return pslverr.
 * Vector loads are checked against a shadow register cleared before each one.
 */
`timescale 1ns/100ps

module tb_mem_stage;

    localparam int NUM_LANES    = 4;
    localparam int APB_WAIT_MAX = 3;
    localparam int MAX_OPS      = 64;
    localparam logic [31:0] err_limit = 32'h800;

    logic CLK, rst, op_valid;
    mem_bus_pkg::access_kind_t op_kind;
    mem_bus_pkg::word_t base, stride, scalar_store_data, reg_wdata, pwdata;
    mem_bus_pkg::word_t prdata = '0;
    rv32v_types_pkg::eew_t eew;
    logic [1:0] uop_num;
    logic [NUM_LANES-1:0] lane_mask;
    mem_bus_pkg::load_type_t load_type;
    mem_bus_pkg::word_t [NUM_LANES-1:0] vs2_data, vwdata;
    logic [NUM_LANES-1:0][3:0] vbyte_wen;
    logic stall, reg_write, bus_error, psel, penable, pwrite;
    logic pready = 1'b0;
    logic pslverr = 1'b0;
    logic [31:0] paddr;
    logic [3:0] pstrb;

    logic [31:0] mem [0:255];
    logic [31:0] shadow [0:NUM_LANES-1];
    logic [31:0] op_f [0:MAX_OPS-1][0:16];
    int waits [0:1023];
    int wait_left, xfer_seq, num_ops, errors, cycles, limit;
    int xfers, reg_writes, err_pulses;
    logic [31:0] last_rdata;
    logic pending;

    mem_stage #(.NUM_LANES(NUM_LANES)) u_mem_stage (.*);

    function automatic logic [31:0] pattern(logic [31:0] a);
        return a * 32'h01010101;
    endfunction

    initial begin
        CLK = 1'b0;
        forever #20 CLK = ~CLK;
    end

    // Cycle limit set once the stimulus is read
    always @(posedge CLK) begin
        cycles++;
        if (cycles >= limit) begin
            $display("Timeout: run did not finish within %0d cycles", limit);
            $display("Simulation FAILED");
            $finish;
        end
    end

    // APB memory with random wait states
    always @(posedge CLK) begin
        if (rst) begin
            pready  <= 1'b0;
            pslverr <= 1'b0;
        end else if (psel && !penable) begin
            wait_left <= waits[xfer_seq % 1024];
            pready    <= (waits[xfer_seq % 1024] == 0);
            prdata    <= mem[paddr[9:2]];
            pslverr   <= (paddr >= err_limit);
            xfer_seq  <= xfer_seq + 1;
        end else if (psel && penable) begin
            if (pready) begin
                if (pwrite && paddr < err_limit) begin
                    for (int k = 0; k < 4; k++) begin
                        if (pstrb[k]) mem[paddr[9:2]][8*k +: 8] <= pwdata[8*k +: 8];
                    end
                end
                pready  <= 1'b0;
                pslverr <= 1'b0;
            end else begin
                wait_left <= wait_left - 1;
                pready    <= (wait_left == 1);
            end
        end
    end

    // Monitors sample pre-edge values
    always @(posedge CLK) begin
        if (!rst) begin
            assert (!pending || psel) else begin
                errors++;
                $display("APB transfer dropped psel before pready at %0t", $time);
            end
            pending = psel && !(penable && pready);
            if (psel && !penable) xfers++;
            if (bus_error) err_pulses++;
            if (reg_write) begin
                reg_writes++;
                last_rdata = reg_wdata;
            end
            for (int b = 0; b < NUM_LANES; b++) begin
                for (int k = 0; k < 4; k++) begin
                    if (vbyte_wen[b][k]) shadow[b][8*k +: 8] = vwdata[b][8*k +: 8];
                end
            end
        end
    end

    task automatic read_stimulus();
        int fd;
        int n;
        string line;
        fd = $fopen("mem_stage_stimulus.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("Could not open the stimulus file");
        end else begin
            while (!$feof(fd) && num_ops < MAX_OPS) begin
                n = $fgets(line, fd);
                if (n > 0 && line.len() > 1 && line.substr(0, 0) != "#") begin
                    n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                        op_f[num_ops][0], op_f[num_ops][1], op_f[num_ops][2],
                        op_f[num_ops][3], op_f[num_ops][4], op_f[num_ops][5],
                        op_f[num_ops][6], op_f[num_ops][7], op_f[num_ops][8],
                        op_f[num_ops][9], op_f[num_ops][10], op_f[num_ops][11],
                        op_f[num_ops][12], op_f[num_ops][13], op_f[num_ops][14],
                        op_f[num_ops][15], op_f[num_ops][16]);
                    if (n == 17) num_ops++;
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic run_op(int i);
        int exp_xfers;
        int kind;
        kind = op_f[i][0];
        exp_xfers = 1;
        if (kind >= 2) exp_xfers = $countones(op_f[i][5][NUM_LANES-1:0]);
        if (kind == 2) begin
            for (int b = 0; b < NUM_LANES; b++) shadow[b] = '0;
        end
        xfers = 0;
        reg_writes = 0;
        err_pulses = 0;
        op_kind   = mem_bus_pkg::access_kind_t'(op_f[i][0][1:0]);
        base      = op_f[i][1];
        stride    = op_f[i][2];
        eew       = rv32v_types_pkg::eew_t'(op_f[i][3][1:0]);
        uop_num   = op_f[i][4][1:0];
        lane_mask = op_f[i][5][NUM_LANES-1:0];
        scalar_store_data = op_f[i][6];
        load_type = mem_bus_pkg::load_type_t'(op_f[i][7][2:0]);
        for (int j = 0; j < NUM_LANES; j++) vs2_data[j] = op_f[i][8+j];
        op_valid = 1'b1;
        do @(posedge CLK); while (stall);
        #2 op_valid = 1'b0;
        @(posedge CLK);
        #2;
        assert (xfers == exp_xfers) else begin
            errors++;
            $display("FAILED op %0d apb_transfers exp %h got %h", i, exp_xfers, xfers);
        end
        assert (err_pulses == op_f[i][16]) else begin
            errors++;
            $display("FAILED op %0d bus_error count exp %h got %h", i, op_f[i][16], err_pulses);
        end
        assert (reg_writes == (kind == 0 ? 1 : 0)) else begin
            errors++;
            $display("FAILED op %0d reg_write count exp %h got %h", i, kind == 0, reg_writes);
        end
        if (kind == 0) begin
            assert (last_rdata == op_f[i][12]) else begin
                errors++;
                $display("FAILED op %0d reg_wdata exp %h got %h", i, op_f[i][12], last_rdata);
            end
        end else if (kind == 2) begin
            for (int b = 0; b < NUM_LANES; b++) begin
                assert (shadow[b] == op_f[i][12+b]) else begin
                    errors++;
                    $display("FAILED op %0d vreg bank %0d exp %h got %h",
                             i, b, op_f[i][12+b], shadow[b]);
                end
            end
        end
    endtask

    initial begin
        errors = $urandom(32'heef655b1);
        errors = 0;
        limit = 1000000;
        rst = 1'b1;
        op_valid = 1'b0;
        op_kind = mem_bus_pkg::acc_sload;
        base = '0;
        stride = '0;
        eew = rv32v_types_pkg::eew_8;
        uop_num = '0;
        lane_mask = '0;
        scalar_store_data = '0;
        load_type = mem_bus_pkg::lw;
        vs2_data = '0;
        pending = 1'b0;
        for (int k = 0; k < 1024; k++) waits[k] = $urandom_range(APB_WAIT_MAX, 0);
        for (int k = 0; k < 256; k++) mem[k] = pattern(k * 4);
        read_stimulus();
        // Worst vector op costs an issue, setup and access cycle per lane plus waits
        limit = num_ops * (NUM_LANES * (3 + APB_WAIT_MAX) + 4) + 10;
        repeat (2) @(posedge CLK);
        #2 rst = 1'b0;
        assert (!stall && !reg_write && vbyte_wen == '0 && !psel && !penable && !bus_error)
        else begin
            errors++;
            $display("Outputs not idle after reset");
        end
        for (int i = 0; i < num_ops; i++) run_op(i);
        $display("Operations: %0d  Errors: %0d", num_ops, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

/* mem_stage_stimulus.txt */
# kind(0 sld 1 sst 2 vld 3 vst) base stride eew uop mask sdata ltype vs2_0..3
# exp0..exp3 (reg_wdata or vreg banks) bus_error_count, all hex
0 80 0 0 0 0 0 2 0 0 0 0 80808080 0 0 0 0
0 81 0 0 0 0 0 0 0 0 0 0 ffffff80 0 0 0 0
0 82 0 0 0 0 0 4 0 0 0 0 00000080 0 0 0 0
0 82 0 0 0 0 0 1 0 0 0 0 ffff8080 0 0 0 0
0 40 0 0 0 0 0 5 0 0 0 0 00004040 0 0 0 0
0 40 0 0 0 0 0 0 0 0 0 0 00000040 0 0 0 0
1 45 0 0 0 0 a5 0 0 0 0 0 0 0 0 0 0
0 44 0 0 0 0 0 2 0 0 0 0 4444a544 0 0 0 0
1 4a 0 0 0 0 1234 1 0 0 0 0 0 0 0 0 0
0 48 0 0 0 0 0 2 0 0 0 0 12344848 0 0 0 0
1 4c 0 0 0 0 deadbeef 2 0 0 0 0 0 0 0 0 0
0 4c 0 0 0 0 0 2 0 0 0 0 deadbeef 0 0 0 0
2 10 1 0 0 f 0 0 0 0 0 0 10101010 0 0 0 0
2 20 2 1 1 f 0 0 0 0 0 0 0 0 28282828 2c2c2c2c 0
2 30 8 2 0 f 0 0 0 0 0 0 30303030 38383838 40404040 12344848 0
2 60 4 2 1 f 0 0 0 0 0 0 0 0 0 0 0
2 50 3 0 2 5 0 0 0 0 0 0 0 0 006c0068 0 0
2 70 1 0 3 a 0 0 0 0 0 0 0 0 0 7c007c00 0
3 90 2 1 0 9 0 0 aaaa bbbb cccc dddd 0 0 0 0 0
0 90 0 0 0 0 0 2 0 0 0 0 9090aaaa 0 0 0 0
0 94 0 0 0 0 0 2 0 0 0 0 dddd9494 0 0 0 0
0 92 0 0 0 0 0 5 0 0 0 0 00009090 0 0 0 0
3 a0 4 2 0 0 0 0 11111111 22222222 33333333 44444444 0 0 0 0 0
0 800 0 0 0 0 0 2 0 0 0 0 00000000 0 0 0 1
3 7f8 4 2 0 c 0 0 1 2 3 4 0 0 0 0 2

/* src.f */
rv32v_types_pkg.sv
mem_bus_pkg.sv
vmem_serializer.sv
load_store_ctrl.sv
vwrite_xbar.sv
mem_stage_ctrl.sv
mem_stage.sv
tb_mem_stage.sv
